// File: verilog/xversat_bus_pkg.sv
package xversat_bus_pkg;

   // datapath word
   localparam int data_w = 32;

   // stage memory holds 64 words
   localparam int mem_addr_w = 6;

   // register index inside a stage
   localparam int cfg_addr_w = 3;

   // one stream element
   typedef struct packed {
      logic              valid;
      logic [data_w-1:0] data;
   } flow_word_t;

   // what a stage hands to the next one in the ring
   typedef struct packed {
      // memory read stream
      flow_word_t mem;
      // alu result stream
      flow_word_t alu;
   } flow_bus_t;

   // bus width, handy for waveform grouping
   localparam int flow_bus_w = $bits(flow_bus_t);

endpackage

// File: verilog/xversat_cfg_pkg.sv
package xversat_cfg_pkg;

   // register map of one stage
   localparam int reg_rd_start   = 0;
   localparam int reg_rd_incr    = 1;
   localparam int reg_count      = 2;
   localparam int reg_wr_start   = 3;
   localparam int reg_alu_op     = 4;
   localparam int reg_alu_sel    = 5;
   localparam int reg_alu_const  = 6;
   localparam int reg_run_status = 7;

   // storage registers, run/status has none
   localparam int n_cfg_reg = 7;

   // alu operations
   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_max,
      op_pass_a
   } alu_op_e;

   // where an alu operand comes from
   typedef enum logic [1:0] {
      sel_own_mem,
      sel_prev_mem,
      sel_prev_alu,
      sel_const
   } src_sel_e;

   // decoded view of the stage registers
   typedef struct packed {
      logic [xversat_bus_pkg::mem_addr_w-1:0] rd_start;
      logic [xversat_bus_pkg::mem_addr_w-1:0] rd_incr;
      logic [xversat_bus_pkg::mem_addr_w:0]   count;
      logic [xversat_bus_pkg::mem_addr_w-1:0] wr_start;
      alu_op_e                                alu_op;
      src_sel_e                               sel_a;
      src_sel_e                               sel_b;
      logic [xversat_bus_pkg::data_w-1:0]     alu_const;
   } stage_cfg_t;

endpackage

// File: verilog/xalu.sv
module xalu
   import xversat_bus_pkg::*, xversat_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  stage_cfg_t cfg,
   input  flow_bus_t  flow_in,
   input  flow_word_t own_mem,
   input  logic       ready,
   output flow_word_t result
);

   flow_word_t        opa;
   flow_word_t        opb;
   logic              fire;
   logic [data_w-1:0] alu_val;
   logic              res_valid;
   logic [data_w-1:0] res_data;

   // const source is always valid
   function automatic flow_word_t pick_src(input src_sel_e sel, input flow_word_t own,
                                           input flow_bus_t prev,
                                           input logic [data_w-1:0] k);
      flow_word_t w;
      case (sel)
         sel_own_mem:  w = own;
         sel_prev_mem: w = prev.mem;
         sel_prev_alu: w = prev.alu;
         default:      w = '{valid: 1'b1, data: k};
      endcase
      return w;
   endfunction

   always_comb begin
      opa  = pick_src(cfg.sel_a, own_mem, flow_in, cfg.alu_const);
      opb  = pick_src(cfg.sel_b, own_mem, flow_in, cfg.alu_const);
      fire = opa.valid && opb.valid;
      case (cfg.alu_op)
         op_add:  alu_val = opa.data + opb.data;
         op_sub:  alu_val = opa.data - opb.data;
         op_and:  alu_val = opa.data & opb.data;
         op_or:   alu_val = opa.data | opb.data;
         op_xor:  alu_val = opa.data ^ opb.data;
         op_max:  alu_val = (opa.data > opb.data) ? opa.data : opb.data;
         default: alu_val = opa.data;
      endcase
   end

   // result waits in place while the write side is full
   always_ff @(posedge clk) begin
      if (reset)
         res_valid <= 1'b0;
      else if (ready)
         res_valid <= fire;
   end

   always_ff @(posedge clk)
      if (ready && fire)
         res_data <= alu_val;

   assign result = '{valid: res_valid, data: res_data};

endmodule

// File: verilog/xmem.sv
module xmem
   import xversat_bus_pkg::*, xversat_cfg_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  stage_cfg_t            cfg,
   input  logic                  start,

   input  logic                  host_valid,
   input  logic                  host_we,
   input  logic [mem_addr_w-1:0] host_addr,
   input  logic [data_w-1:0]     host_wdata,
   output logic [data_w-1:0]     host_rdata,

   input  flow_word_t            wr_in,
   output logic                  wr_ready,
   output flow_word_t            rd_out,
   output logic                  done
);

   logic [data_w-1:0] mem [1 << mem_addr_w];

   // address generators
   logic [mem_addr_w-1:0] rd_addr;
   logic [mem_addr_w-1:0] wr_addr;
   logic [mem_addr_w:0]   rd_left;
   logic [mem_addr_w:0]   wr_left;

   // write holding register
   logic              hold_valid;
   logic [data_w-1:0] hold_data;

   // single memory port
   logic [mem_addr_w-1:0] port_addr;
   logic [data_w-1:0]     port_wdata;
   logic [data_w-1:0]     port_rdata;
   logic                  port_we;
   logic                  rd_valid_q;

   logic rd_req;
   logic wr_req;
   logic in_take;
   logic host_grant;
   logic wr_grant;
   logic rd_grant;

   always_comb begin
      in_take = wr_in.valid && !hold_valid && wr_left != '0;
      rd_req  = rd_left != '0;
      wr_req  = hold_valid || in_take;

      // host first, then writes, then reads
      host_grant = host_valid;
      wr_grant   = wr_req && !host_grant;
      rd_grant   = rd_req && !host_grant && !wr_req;

      if (host_grant)
         port_addr = host_addr;
      else if (wr_req)
         port_addr = wr_addr;
      else
         port_addr = rd_addr;

      if (host_grant)
         port_wdata = host_wdata;
      else if (hold_valid)
         port_wdata = hold_data;
      else
         port_wdata = wr_in.data;

      port_we = (host_grant && host_we) || wr_grant;
   end

   always_ff @(posedge clk) begin
      if (port_we)
         mem[port_addr] <= port_wdata;
      if ((host_grant && !host_we) || rd_grant)
         port_rdata <= mem[port_addr];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_left    <= '0;
         wr_left    <= '0;
         hold_valid <= 1'b0;
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_grant;
         hold_valid <= wr_req && !wr_grant;
         if (start) begin
            rd_left <= cfg.count;
            wr_left <= cfg.count;
         end else begin
            if (rd_grant)
               rd_left <= rd_left - 1'b1;
            if (wr_grant)
               wr_left <= wr_left - 1'b1;
         end
      end
   end

   // addresses wrap modulo memory size
   always_ff @(posedge clk) begin
      if (start)
         rd_addr <= cfg.rd_start;
      else if (rd_grant)
         rd_addr <= rd_addr + cfg.rd_incr;

      if (start)
         wr_addr <= cfg.wr_start;
      else if (wr_grant)
         wr_addr <= wr_addr + 1'b1;

      if (in_take && !wr_grant)
         hold_data <= wr_in.data;
   end

   assign wr_ready   = !hold_valid;
   assign done       = wr_grant && wr_left == 1;
   assign host_rdata = port_rdata;
   assign rd_out     = '{valid: rd_valid_q, data: port_rdata};

endmodule

// File: verilog/xstage.sv
module xstage
   import xversat_bus_pkg::*, xversat_cfg_pkg::*;
#(
   parameter int n_stage = 4
) (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  ctr_valid,
   input  logic                  ctr_we,
   input  logic [cfg_addr_w-1:0] ctr_addr,
   input  logic [data_w-1:0]     ctr_data_in,
   output logic [data_w-1:0]     ctr_data_out,

   input  logic                  data_valid,
   input  logic                  data_we,
   input  logic [mem_addr_w-1:0] data_addr,
   input  logic [data_w-1:0]     data_data_in,
   output logic [data_w-1:0]     data_data_out,

   input  flow_bus_t             flow_in,
   output flow_bus_t             flow_out
);

   logic [data_w-1:0] cfg_reg [n_cfg_reg];
   stage_cfg_t        cfg;
   logic              cfg_we;
   logic              start;
   logic              busy;
   logic              done;
   logic              wr_ready;
   flow_word_t        mem_rd;
   flow_word_t        alu_res;

   // the ring needs a previous stage to talk to
   if (n_stage < 2) begin : g_ring_check
      $error("xstage: ring needs at least two stages");
   end

   assign cfg_we = ctr_valid && ctr_we;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < n_cfg_reg; r++)
            cfg_reg[r] <= '0;
      end else if (cfg_we && ctr_addr != reg_run_status) begin
         cfg_reg[ctr_addr] <= ctr_data_in;
      end
   end

   always_comb begin
      cfg.rd_start  = cfg_reg[reg_rd_start][mem_addr_w-1:0];
      cfg.rd_incr   = cfg_reg[reg_rd_incr][mem_addr_w-1:0];
      cfg.count     = cfg_reg[reg_count][mem_addr_w:0];
      cfg.wr_start  = cfg_reg[reg_wr_start][mem_addr_w-1:0];
      cfg.alu_op    = alu_op_e'(cfg_reg[reg_alu_op][2:0]);
      cfg.sel_a     = src_sel_e'(cfg_reg[reg_alu_sel][1:0]);
      cfg.sel_b     = src_sel_e'(cfg_reg[reg_alu_sel][3:2]);
      cfg.alu_const = cfg_reg[reg_alu_const];
   end

   // run is ignored while busy or with nothing to do
   assign start = cfg_we && ctr_addr == reg_run_status && ctr_data_in[0]
                  && !busy && cfg.count != '0;

   always_ff @(posedge clk) begin
      if (reset)
         busy <= 1'b0;
      else if (start)
         busy <= 1'b1;
      else if (done)
         busy <= 1'b0;
   end

   always_comb begin
      if (ctr_addr == reg_run_status)
         ctr_data_out = {{(data_w-1){1'b0}}, busy};
      else
         ctr_data_out = cfg_reg[ctr_addr];
   end

   xmem mem_inst (
      .clk       (clk),
      .reset     (reset),
      .cfg       (cfg),
      .start     (start),
      .host_valid(data_valid),
      .host_we   (data_we),
      .host_addr (data_addr),
      .host_wdata(data_data_in),
      .host_rdata(data_data_out),
      .wr_in     (alu_res),
      .wr_ready  (wr_ready),
      .rd_out    (mem_rd),
      .done      (done)
   );

   xalu alu_inst (
      .clk    (clk),
      .reset  (reset),
      .cfg    (cfg),
      .flow_in(flow_in),
      .own_mem(flow_out.mem),
      .ready  (wr_ready),
      .result (alu_res)
   );

   // both streams are registered in their units
   assign flow_out = '{mem: mem_rd, alu: alu_res};

endmodule

// File: verilog/xversat.sv
module xversat
   import xversat_bus_pkg::*;
#(
   parameter int n_stage    = 4,
   parameter int ctr_addr_w = 8
) (
   input  logic                  clk,
   input  logic                  reset,

   // control interface
   input  logic                  ctr_valid,
   input  logic [ctr_addr_w-1:0] ctr_addr,
   input  logic                  ctr_we,
   input  logic [data_w-1:0]     ctr_data_in,
   output logic [data_w-1:0]     ctr_data_out,

   // data interface
   input  logic                  data_valid,
   input  logic [ctr_addr_w-1:0] data_addr,
   input  logic                  data_we,
   input  logic [data_w-1:0]     data_data_in,
   output logic [data_w-1:0]     data_data_out
);

   localparam int stage_w = $clog2(n_stage);

   // stage field of each address
   logic [stage_w-1:0] ctr_stage;
   logic [stage_w-1:0] data_stage;
   logic [n_stage-1:0] stage_ctr_valid;
   logic [n_stage-1:0] stage_data_valid;
   logic [data_w-1:0]  stage_ctr_rdata [n_stage];
   logic [data_w-1:0]  stage_data_rdata [n_stage];

   // remembered for the registered data read
   logic [stage_w-1:0] data_sel_q;
   logic               data_rd_q;

   flow_bus_t stage_flow [n_stage];

   assign ctr_stage  = ctr_addr[ctr_addr_w-1 -: stage_w];
   assign data_stage = data_addr[ctr_addr_w-1 -: stage_w];

   // one-hot stage selects
   always_comb begin
      stage_ctr_valid  = '0;
      stage_data_valid = '0;
      for (int j = 0; j < n_stage; j++) begin
         if (ctr_stage == stage_w'(j))
            stage_ctr_valid[j] = ctr_valid;
         if (data_stage == stage_w'(j))
            stage_data_valid[j] = data_valid;
      end
   end

   // control reads come back in the same cycle
   always_comb begin
      ctr_data_out = '0;
      for (int j = 0; j < n_stage; j++)
         if (stage_ctr_valid[j])
            ctr_data_out = stage_ctr_rdata[j];
   end

   always_ff @(posedge clk) begin
      if (reset)
         data_rd_q <= 1'b0;
      else
         data_rd_q <= data_valid && !data_we;
   end

   always_ff @(posedge clk)
      data_sel_q <= data_stage;

   assign data_data_out = data_rd_q ? stage_data_rdata[data_sel_q] : '0;

   // ring of stages, stage 0 listens to the last one
   for (genvar i = 0; i < n_stage; i++) begin : versat_array
      localparam int prev = (i == 0) ? n_stage - 1 : i - 1;

      xstage #(
         .n_stage(n_stage)
      ) stage (
         .clk          (clk),
         .reset        (reset),
         .ctr_valid    (stage_ctr_valid[i]),
         .ctr_we       (ctr_we),
         .ctr_addr     (ctr_addr[cfg_addr_w-1:0]),
         .ctr_data_in  (ctr_data_in),
         .ctr_data_out (stage_ctr_rdata[i]),
         .data_valid   (stage_data_valid[i]),
         .data_we      (data_we),
         .data_addr    (data_addr[mem_addr_w-1:0]),
         .data_data_in (data_data_in),
         .data_data_out(stage_data_rdata[i]),
         .flow_in      (stage_flow[prev]),
         .flow_out     (stage_flow[i])
      );
   end

endmodule

// File: tests/xversat_assert.sv
module xversat_assert
   import xversat_bus_pkg::*;
(
   input logic                  clk,
   input logic                  reset,
   input logic                  busy,
   input logic [mem_addr_w:0]   wr_left,
   input logic                  host_valid,
   input logic                  host_we,
   input logic [mem_addr_w-1:0] host_addr,
   input logic [mem_addr_w-1:0] port_addr,
   input logic                  port_we,
   input flow_bus_t             flow_out
);

   int fail_count = 0;

   // busy stays up while engine writes are still owed
   busy_until_done: assert property (@(posedge clk) disable iff (reset)
      wr_left != '0 |-> busy)
   else begin
      fail_count++;
      $error("stage busy low while the memory engine still had writes to do");
   end

   // host owns the memory port in its cycle
   no_write_under_host: assert property (@(posedge clk) disable iff (reset)
      host_valid |-> port_addr == host_addr && port_we == host_we)
   else begin
      fail_count++;
      $error("memory port not given to the host while the host used it");
   end

   flows_quiet_in_reset: assert property (@(posedge clk)
      reset |=> !flow_out.mem.valid && !flow_out.alu.valid)
   else begin
      fail_count++;
      $error("flow bus valid high during reset");
   end

endmodule

// File: tests/xversat_tb.sv
module xversat_tb
   import xversat_bus_pkg::*, xversat_cfg_pkg::*;
();

   localparam int n_stage    = 4;
   localparam int ctr_addr_w = 8;
   localparam int stage_w    = $clog2(n_stage);
   localparam int mem_words  = 1 << mem_addr_w;
   // whole run is near 3000 cycles, so this leaves a wide margin
   localparam int timeout_cycles = 20000;

   logic                  clk;
   logic                  reset;
   logic                  ctr_valid;
   logic [ctr_addr_w-1:0] ctr_addr;
   logic                  ctr_we;
   logic [data_w-1:0]     ctr_data_in;
   logic [data_w-1:0]     ctr_data_out;
   logic                  data_valid;
   logic [ctr_addr_w-1:0] data_addr;
   logic                  data_we;
   logic [data_w-1:0]     data_data_in;
   logic [data_w-1:0]     data_data_out;

   // reference copies of every stage
   logic [data_w-1:0] mem_model [n_stage][mem_words];
   logic [data_w-1:0] cfg_model [n_stage][n_cfg_reg];
   int checks;
   int errors;
   int cycles;
   int bind_fails [n_stage];

   xversat #(
      .n_stage   (n_stage),
      .ctr_addr_w(ctr_addr_w)
   ) xversat_inst (
      .clk          (clk),
      .reset        (reset),
      .ctr_valid    (ctr_valid),
      .ctr_addr     (ctr_addr),
      .ctr_we       (ctr_we),
      .ctr_data_in  (ctr_data_in),
      .ctr_data_out (ctr_data_out),
      .data_valid   (data_valid),
      .data_addr    (data_addr),
      .data_we      (data_we),
      .data_data_in (data_data_in),
      .data_data_out(data_data_out)
   );

   bind xstage xversat_assert engine_check (
      .clk       (clk),
      .reset     (reset),
      .busy      (busy),
      .wr_left   (mem_inst.wr_left),
      .host_valid(data_valid),
      .host_we   (data_we),
      .host_addr (data_addr),
      .port_addr (mem_inst.port_addr),
      .port_we   (mem_inst.port_we),
      .flow_out  (flow_out)
   );

   for (genvar g = 0; g < n_stage; g++) begin : g_bind_count
      assign bind_fails[g] = xversat_inst.versat_array[g].stage.engine_check.fail_count;
   end

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("Timeout: the stage engines never finished within %0d cycles", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   function automatic int assert_total();
      int sum;
      sum = 0;
      for (int i = 0; i < n_stage; i++)
         sum += bind_fails[i];
      return sum;
   endfunction

   // stage number in the top address bits
   function automatic logic [ctr_addr_w-1:0] stage_addr(input int s, input int low);
      return ctr_addr_w'((s << (ctr_addr_w - stage_w)) + low);
   endfunction

   function automatic int sel_code(input src_sel_e a, input src_sel_e b);
      return int'(a) | (int'(b) << 2);
   endfunction

   function automatic logic [data_w-1:0] alu_model(input int op, input logic [data_w-1:0] a,
                                                   input logic [data_w-1:0] b);
      case (alu_op_e'(op))
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         op_max:  return (a > b) ? a : b;
         default: return a;
      endcase
   endfunction

   task automatic check_value(input string what, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("Error at time %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic ctr_write(input int s, input int idx, input logic [data_w-1:0] v);
      @(negedge clk);
      ctr_valid   = 1'b1;
      ctr_we      = 1'b1;
      ctr_addr    = stage_addr(s, idx);
      ctr_data_in = v;
      if (idx != reg_run_status)
         cfg_model[s][idx] = v;
      @(negedge clk);
      ctr_valid = 1'b0;
      ctr_we    = 1'b0;
   endtask

   task automatic ctr_read(input int s, input int idx, output logic [data_w-1:0] v);
      @(negedge clk);
      ctr_valid = 1'b1;
      ctr_addr  = stage_addr(s, idx);
      // combinational read path
      #2 v = ctr_data_out;
      @(negedge clk);
      ctr_valid = 1'b0;
   endtask

   task automatic mem_write(input int s, input int w, input logic [data_w-1:0] v);
      @(negedge clk);
      data_valid   = 1'b1;
      data_we      = 1'b1;
      data_addr    = stage_addr(s, w);
      data_data_in = v;
      mem_model[s][w] = v;
      @(negedge clk);
      data_valid = 1'b0;
      data_we    = 1'b0;
   endtask

   // word shows up one cycle after the request
   task automatic mem_read(input int s, input int w, output logic [data_w-1:0] v);
      @(negedge clk);
      data_valid = 1'b1;
      data_addr  = stage_addr(s, w);
      @(negedge clk);
      v = data_data_out;
      data_valid = 1'b0;
   endtask

   task automatic check_memory(input int s);
      logic [data_w-1:0] v;
      for (int w = 0; w < mem_words; w++) begin
         mem_read(s, w, v);
         check_value($sformatf("stage %0d word %0d", s, w), v, mem_model[s][w]);
      end
   endtask

   // reads stay within words 0..42, writes within 44..63
   task automatic pick_run(output int rs, output int ri, output int cnt, output int ws);
      cnt = 1 + $urandom % 10;
      rs  = $urandom % 16;
      ri  = $urandom % 4;
      ws  = 44 + $urandom % (21 - cnt);
   endtask

   task automatic setup_stage(input int s, input int rs, input int ri, input int cnt,
                              input int ws, input int op, input int sel,
                              input logic [data_w-1:0] k);
      ctr_write(s, reg_rd_start, rs);
      ctr_write(s, reg_rd_incr, ri);
      ctr_write(s, reg_count, cnt);
      ctr_write(s, reg_wr_start, ws);
      ctr_write(s, reg_alu_op, op);
      ctr_write(s, reg_alu_sel, sel);
      ctr_write(s, reg_alu_const, k);
   endtask

   task automatic model_run(input int s, input int rs, input int ri, input int cnt,
                            input int ws, input int op, input logic [data_w-1:0] k);
      for (int j = 0; j < cnt; j++)
         mem_model[s][(ws + j) % mem_words] =
            alu_model(op, mem_model[s][(rs + j * ri) % mem_words], k);
   endtask

   task automatic wait_idle(input int s);
      logic [data_w-1:0] st;
      do
         ctr_read(s, reg_run_status, st);
      while (st[0]);
   endtask

   initial begin
      int rs, ri, cnt, ws, ws2, s, s1, s2, w, op1, op2, hits;
      logic [data_w-1:0] v, k1, k2, x;
      logic [n_stage-1:0] mask;

      clk          = 1'b0;
      reset        = 1'b1;
      ctr_valid    = 1'b0;
      ctr_addr     = '0;
      ctr_we       = 1'b0;
      ctr_data_in  = '0;
      data_valid   = 1'b0;
      data_addr    = '0;
      data_we      = 1'b0;
      data_data_in = '0;
      checks       = 0;
      errors       = 0;
      cycles       = 0;
      void'($urandom(32'hfb16276e));
      for (int i = 0; i < n_stage; i++)
         for (int r = 0; r < n_cfg_reg; r++)
            cfg_model[i][r] = '0;
      repeat (16) @(negedge clk);
      reset = 1'b0;

      // idle state after reset
      check_value("control read port", ctr_data_out, '0);
      check_value("data read port", data_data_out, '0);
      for (int i = 0; i < n_stage; i++) begin
         ctr_read(i, reg_run_status, v);
         check_value($sformatf("stage %0d busy", i), v, '0);
      end
      for (int j = 0; j < 4; j++) begin
         s = $urandom % n_stage;
         w = $urandom % mem_words;
         mem_write(s, w, $urandom);
         mem_read(s, w, v);
         check_value($sformatf("stage %0d word %0d", s, w), v, mem_model[s][w]);
      end

      // fill every memory, then read back
      for (int i = 0; i < n_stage; i++)
         for (int j = 0; j < mem_words; j++)
            mem_write(i, j, $urandom);
      for (int i = 0; i < n_stage; i++)
         check_memory(i);

      // config registers on a random subset of stages
      mask = n_stage'(1 + $urandom % ((1 << n_stage) - 2));
      for (int i = 0; i < n_stage; i++)
         if (mask[i])
            for (int r = 0; r < n_cfg_reg; r++)
               ctr_write(i, r, $urandom);
      for (int i = 0; i < n_stage; i++)
         for (int r = 0; r < n_cfg_reg; r++) begin
            ctr_read(i, r, v);
            check_value($sformatf("stage %0d register %0d", i, r), v, cfg_model[i][r]);
         end

      // one stage per opcode, own memory against the constant
      for (int op = 0; op <= int'(op_pass_a); op++) begin
         s = $urandom % n_stage;
         pick_run(rs, ri, cnt, ws);
         k1 = $urandom;
         setup_stage(s, rs, ri, cnt, ws, op, sel_code(sel_own_mem, sel_const), k1);
         model_run(s, rs, ri, cnt, ws, op, k1);
         ctr_write(s, reg_run_status, 1);
         wait_idle(s);
         check_memory(s);
      end

      // host reads below the write window while the engine runs
      s = $urandom % n_stage;
      pick_run(rs, ri, cnt, ws);
      cnt = 10;
      ws  = 44 + $urandom % 11;
      op1 = $urandom % 7;
      k1  = $urandom;
      setup_stage(s, rs, ri, cnt, ws, op1, sel_code(sel_own_mem, sel_const), k1);
      model_run(s, rs, ri, cnt, ws, op1, k1);
      ctr_write(s, reg_run_status, 1);
      hits = 0;
      ctr_read(s, reg_run_status, v);
      while (v[0]) begin
         w = $urandom % 44;
         mem_read(s, w, x);
         check_value($sformatf("stage %0d word %0d while busy", s, w), x, mem_model[s][w]);
         hits++;
         ctr_read(s, reg_run_status, v);
      end
      checks++;
      assert (hits > 0)
      else begin
         errors++;
         $display("No host read overlapped the running engine of stage %0d", s);
      end
      check_memory(s);

      // last stage consumes the alu stream of the stage before it
      s1 = n_stage - 2;
      s2 = n_stage - 1;
      pick_run(rs, ri, cnt, ws);
      ws2 = $urandom % (mem_words - cnt + 1);
      op1 = $urandom % 7;
      op2 = $urandom % 7;
      k1  = $urandom;
      k2  = $urandom;
      setup_stage(s2, 0, 1, cnt, ws2, op2, sel_code(sel_prev_alu, sel_const), k2);
      setup_stage(s1, rs, ri, cnt, ws, op1, sel_code(sel_own_mem, sel_const), k1);
      for (int j = 0; j < cnt; j++) begin
         x = alu_model(op1, mem_model[s1][(rs + j * ri) % mem_words], k1);
         mem_model[s2][(ws2 + j) % mem_words] = alu_model(op2, x, k2);
      end
      model_run(s1, rs, ri, cnt, ws, op1, k1);
      ctr_write(s2, reg_run_status, 1);
      ctr_write(s1, reg_run_status, 1);
      wait_idle(s1);
      wait_idle(s2);
      check_memory(s1);
      check_memory(s2);

      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, errors, assert_total());
      if (errors == 0 && assert_total() == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: xversat.f
verilog/xversat_bus_pkg.sv
verilog/xversat_cfg_pkg.sv
verilog/xalu.sv
verilog/xmem.sv
verilog/xstage.sv
verilog/xversat.sv
tests/xversat_assert.sv
tests/xversat_tb.sv

// File: Makefile
# Verilator build and run of the xversat testbench

VERILATOR ?= verilator
TOP       ?= xversat_tb
FILELIST  ?= xversat.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the testbench prints its pass line
run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
